// ==== cache_pkg.sv ====
package cache_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  // byte offset bits inside one line
  localparam int OFFSET_W       = $clog2(WORDS_PER_LINE * WORD_W / 8);

  typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

  typedef logic [ADDR_W-OFFSET_W-1:0] tag_t;

  typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

  typedef struct packed {
    logic  valid;
    logic  dirty;
    tag_t  tag;
    line_t data;
  } line_entry_t;

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    ST_EVICT     = 3'd1,
    ST_FILL_REQ  = 3'd2,
    ST_FILL_WAIT = 3'd3,
    ST_RESPOND   = 3'd4
  } ctrl_state_e;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

  // cpu side, one word per request
  typedef struct packed {
    logic [cache_pkg::ADDR_W-1:0]   addr;
    logic [cache_pkg::WORD_W-1:0]   wdata;
    logic                           we;
    logic [cache_pkg::WORD_W/8-1:0] sel;
  } cpu_req_t;

  typedef struct packed {
    logic                         ack;
    logic [cache_pkg::WORD_W-1:0] rdata;
  } cpu_rsp_t;

  typedef enum logic [1:0] {
    MEM_READ  = 2'd0,
    MEM_WRITE = 2'd1
  } mem_op_e;

  // memory side moves whole lines
  typedef struct packed {
    logic                         cyc;
    logic                         stb;
    mem_op_e                      op;
    logic [cache_pkg::ADDR_W-1:0] addr;
    cache_pkg::line_t             data;
  } mem_req_t;

  typedef struct packed {
    logic             stall;
    logic             ack;
    cache_pkg::line_t rdata;
  } mem_rsp_t;

endpackage

// ==== req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  bus_pkg::cpu_req_t req_i,
  output logic              stall_o,
  input  logic              pop_i,
  output logic              valid_o,
  output bus_pkg::cpu_req_t head_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  bus_pkg::cpu_req_t mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign valid_o = (count_q != '0);
  assign do_pop  = pop_i && valid_o;
  assign head_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (push_i)
    begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      stall_o  <= 1'b0;
    end
    else
    begin
      if (push_i)
      begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop)
      begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // one cycle late, so one more push can still land
      stall_o <= (count_q >= CNT_W'(FIFO_DEPTH - 1));
    end
  end

endmodule

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store #(
  parameter  int NUM_LINES = 8,
  localparam int IDX_W     = $clog2(NUM_LINES)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  cache_pkg::tag_t        lookup_tag_i,
  output logic                   hit_o,
  output logic [IDX_W-1:0]       hit_way_o,
  output logic                   free_o,
  output logic [IDX_W-1:0]       free_way_o,
  input  logic [IDX_W-1:0]       rd_way_i,
  output cache_pkg::line_entry_t rd_entry_o,
  input  logic                   wr_en_i,
  input  logic [IDX_W-1:0]       wr_way_i,
  input  cache_pkg::line_entry_t wr_entry_i
);

  cache_pkg::line_entry_t lines_q [NUM_LINES];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_LINES; i++)
      begin
        lines_q[i].valid <= 1'b0;
      end
    end
    else if (wr_en_i)
    begin
      lines_q[wr_way_i] <= wr_entry_i;
    end
  end

  assign rd_entry_o = lines_q[rd_way_i];

  // associative compare, lowest matching way wins
  always_comb
  begin
    hit_o     = 1'b0;
    hit_way_o = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (lines_q[i].valid && (lines_q[i].tag == lookup_tag_i))
      begin
        hit_o     = 1'b1;
        hit_way_o = IDX_W'(i);
      end
    end
  end

  // lowest invalid way
  always_comb
  begin
    free_o     = 1'b0;
    free_way_o = '0;
    for (int i = NUM_LINES - 1; i >= 0; i--)
    begin
      if (!lines_q[i].valid)
      begin
        free_o     = 1'b1;
        free_way_o = IDX_W'(i);
      end
    end
  end

endmodule

// ==== lru_tracker.sv ====
`timescale 1ns/1ps

module lru_tracker #(
  parameter  int NUM_LINES = 8,
  localparam int IDX_W     = $clog2(NUM_LINES)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             touch_i,
  input  logic [IDX_W-1:0] touch_way_i,
  output logic [IDX_W-1:0] lru_way_o
);

  localparam int PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;

  // set when the lower index of the pair was used more recently
  logic [PAIRS-1:0] newer_q;
  logic [PAIRS-1:0] newer_d;
  logic             oldest;
  logic             found;

  function automatic int pair_idx(input int lo, input int hi);
    return lo * NUM_LINES - lo * (lo + 1) / 2 + hi - lo - 1;
  endfunction

  always_comb
  begin
    newer_d = newer_q;
    for (int i = 0; i < NUM_LINES; i++)
    begin
      for (int j = i + 1; j < NUM_LINES; j++)
      begin
        if (touch_way_i == IDX_W'(i))
        begin
          newer_d[pair_idx(i, j)] = 1'b1;
        end
        else if (touch_way_i == IDX_W'(j))
        begin
          newer_d[pair_idx(i, j)] = 1'b0;
        end
      end
    end
  end

  // all zero means index order, way 0 oldest
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      newer_q <= '0;
    end
    else if (touch_i)
    begin
      newer_q <= newer_d;
    end
  end

  always_comb
  begin
    lru_way_o = '0;
    found     = 1'b0;
    oldest    = 1'b0;
    for (int k = 0; k < NUM_LINES; k++)
    begin
      oldest = 1'b1;
      for (int m = 0; m < NUM_LINES; m++)
      begin
        if (m < k)
        begin
          if (!newer_q[pair_idx(m, k)])
          begin
            oldest = 1'b0;
          end
        end
        else if (m > k)
        begin
          if (newer_q[pair_idx(k, m)])
          begin
            oldest = 1'b0;
          end
        end
      end
      if (oldest && !found)
      begin
        lru_way_o = IDX_W'(k);
        found     = 1'b1;
      end
    end
  end

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
  parameter  int NUM_LINES = 8,
  localparam int IDX_W     = $clog2(NUM_LINES)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid_i,
  input  bus_pkg::cpu_req_t      req_i,
  output logic                   pop_o,
  input  logic                   hit_i,
  input  logic [IDX_W-1:0]       hit_way_i,
  input  logic                   free_i,
  input  logic [IDX_W-1:0]       free_way_i,
  input  logic [IDX_W-1:0]       lru_way_i,
  output logic [IDX_W-1:0]       rd_way_o,
  input  cache_pkg::line_entry_t rd_entry_i,
  output logic                   wr_en_o,
  output logic [IDX_W-1:0]       wr_way_o,
  output cache_pkg::line_entry_t wr_entry_o,
  output logic                   touch_o,
  output logic [IDX_W-1:0]       touch_way_o,
  output bus_pkg::mem_req_t      mem_req_o,
  input  bus_pkg::mem_rsp_t      mem_rsp_i,
  output bus_pkg::cpu_rsp_t      cpu_rsp_o
);

  cache_pkg::ctrl_state_e       state_q;
  logic [IDX_W-1:0]             way_q;
  logic [IDX_W-1:0]             sel_way;
  cache_pkg::tag_t              req_tag;
  cache_pkg::word_sel_t         word_sel;
  logic [cache_pkg::WORD_W-1:0] byte_mask;
  logic [cache_pkg::WORD_W-1:0] cur_word;
  logic [cache_pkg::WORD_W-1:0] merged_word;
  bus_pkg::mem_req_t            evict_req;
  bus_pkg::mem_req_t            fill_req;

  assign req_tag  = req_i.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
  assign word_sel = req_i.addr[cache_pkg::OFFSET_W-1 -: $bits(cache_pkg::word_sel_t)];

  // hit, then free, then lru
  assign sel_way     = hit_i ? hit_way_i : (free_i ? free_way_i : lru_way_i);
  assign rd_way_o    = (state_q == cache_pkg::ST_IDLE) ? sel_way : way_q;
  assign touch_o     = (state_q == cache_pkg::ST_IDLE) && req_valid_i;
  assign touch_way_o = sel_way;
  assign wr_way_o    = way_q;
  assign pop_o       = (state_q == cache_pkg::ST_RESPOND);

  always_comb
  begin
    for (int b = 0; b < cache_pkg::WORD_W / 8; b++)
    begin
      byte_mask[b*8 +: 8] = {8{req_i.sel[b]}};
    end
    cur_word    = rd_entry_i.data[word_sel];
    merged_word = req_i.we ? ((req_i.wdata & byte_mask) | (cur_word & ~byte_mask)) : cur_word;
  end

  // victim write-back and line fill requests
  always_comb
  begin
    evict_req.cyc  = 1'b1;
    evict_req.stb  = 1'b1;
    evict_req.op   = bus_pkg::MEM_WRITE;
    evict_req.addr = {rd_entry_i.tag, {cache_pkg::OFFSET_W{1'b0}}};
    evict_req.data = rd_entry_i.data;
    fill_req       = evict_req;
    fill_req.op    = bus_pkg::MEM_READ;
    fill_req.addr  = {req_tag, {cache_pkg::OFFSET_W{1'b0}}};
    fill_req.data  = '0;
  end

  always_comb
  begin
    wr_entry_o = rd_entry_i;
    wr_en_o    = 1'b0;
    if (state_q == cache_pkg::ST_FILL_WAIT)
    begin
      wr_entry_o.valid = 1'b1;
      wr_entry_o.dirty = 1'b0;
      wr_entry_o.tag   = req_tag;
      wr_entry_o.data  = mem_rsp_i.rdata;
      wr_en_o          = mem_rsp_i.ack;
    end
    else if (state_q == cache_pkg::ST_RESPOND)
    begin
      wr_entry_o.data[word_sel] = merged_word;
      wr_entry_o.dirty          = 1'b1;
      wr_en_o                   = req_i.we;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q       <= cache_pkg::ST_IDLE;
      cpu_rsp_o.ack <= 1'b0;
      mem_req_o.cyc <= 1'b0;
      mem_req_o.stb <= 1'b0;
    end
    else
    begin
      cpu_rsp_o.ack <= 1'b0;
      case (state_q)
        cache_pkg::ST_IDLE:
        begin
          if (req_valid_i)
          begin
            way_q <= sel_way;
            if (hit_i)
            begin
              state_q <= cache_pkg::ST_RESPOND;
            end
            else if (rd_entry_i.valid && rd_entry_i.dirty)
            begin
              mem_req_o <= evict_req;
              state_q   <= cache_pkg::ST_EVICT;
            end
            else
            begin
              mem_req_o <= fill_req;
              state_q   <= cache_pkg::ST_FILL_REQ;
            end
          end
        end
        cache_pkg::ST_EVICT:
        begin
          // write needs no ack, go straight to the fill
          if (!mem_rsp_i.stall)
          begin
            mem_req_o <= fill_req;
            state_q   <= cache_pkg::ST_FILL_REQ;
          end
        end
        cache_pkg::ST_FILL_REQ:
        begin
          if (!mem_rsp_i.stall)
          begin
            mem_req_o.cyc <= 1'b0;
            mem_req_o.stb <= 1'b0;
            state_q       <= cache_pkg::ST_FILL_WAIT;
          end
        end
        cache_pkg::ST_FILL_WAIT:
        begin
          if (mem_rsp_i.ack)
          begin
            state_q <= cache_pkg::ST_RESPOND;
          end
        end
        cache_pkg::ST_RESPOND:
        begin
          cpu_rsp_o.ack   <= 1'b1;
          cpu_rsp_o.rdata <= merged_word & byte_mask;
          state_q         <= cache_pkg::ST_IDLE;
        end
        default:
        begin
          state_q <= cache_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top #(
  parameter int NUM_LINES  = 8,
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  bus_pkg::cpu_req_t cpu_req_i,
  output logic              stall_o,
  output bus_pkg::cpu_rsp_t cpu_rsp_o,
  output bus_pkg::mem_req_t mem_req_o,
  input  bus_pkg::mem_rsp_t mem_rsp_i
);

  localparam int IDX_W = $clog2(NUM_LINES);

  logic                   push;
  logic                   pop;
  logic                   head_valid;
  bus_pkg::cpu_req_t      head;
  logic                   hit;
  logic [IDX_W-1:0]       hit_way;
  logic                   free;
  logic [IDX_W-1:0]       free_way;
  logic [IDX_W-1:0]       lru_way;
  logic [IDX_W-1:0]       rd_way;
  cache_pkg::line_entry_t rd_entry;
  logic                   wr_en;
  logic [IDX_W-1:0]       wr_way;
  cache_pkg::line_entry_t wr_entry;
  logic                   touch;
  logic [IDX_W-1:0]       touch_way;

  assign push = cyc_i & stb_i & ~stall_o;

  req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_req_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (push),
    .req_i   (cpu_req_i),
    .stall_o (stall_o),
    .pop_i   (pop),
    .valid_o (head_valid),
    .head_o  (head)
  );

  line_store #(.NUM_LINES(NUM_LINES)) u_line_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_tag_i (head.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W]),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .free_o       (free),
    .free_way_o   (free_way),
    .rd_way_i     (rd_way),
    .rd_entry_o   (rd_entry),
    .wr_en_i      (wr_en),
    .wr_way_i     (wr_way),
    .wr_entry_i   (wr_entry)
  );

  lru_tracker #(.NUM_LINES(NUM_LINES)) u_lru_tracker (
    .clk         (clk),
    .rst         (rst),
    .touch_i     (touch),
    .touch_way_i (touch_way),
    .lru_way_o   (lru_way)
  );

  cache_ctrl #(.NUM_LINES(NUM_LINES)) u_cache_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (head_valid),
    .req_i       (head),
    .pop_o       (pop),
    .hit_i       (hit),
    .hit_way_i   (hit_way),
    .free_i      (free),
    .free_way_i  (free_way),
    .lru_way_i   (lru_way),
    .rd_way_o    (rd_way),
    .rd_entry_i  (rd_entry),
    .wr_en_o     (wr_en),
    .wr_way_o    (wr_way),
    .wr_entry_o  (wr_entry),
    .touch_o     (touch),
    .touch_way_o (touch_way),
    .mem_req_o   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i),
    .cpu_rsp_o   (cpu_rsp_o)
  );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                         clk,
  input  logic                         rst,
  input  bus_pkg::mem_req_t            req_i,
  output bus_pkg::mem_rsp_t            rsp_o,
  output logic                         wb_o,
  output logic [cache_pkg::ADDR_W-1:0] wb_addr_o,
  output cache_pkg::line_t             wb_data_o
);

  // lines written back so far, keyed by tag
  cache_pkg::line_t lines_a [cache_pkg::tag_t];
  cache_pkg::line_t fill_line;
  cache_pkg::tag_t  req_tag;
  logic             pending;
  int unsigned      delay;

  assign req_tag = req_i.addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];

  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic cache_pkg::line_t read_line(input cache_pkg::tag_t tag);
    cache_pkg::line_t line;
    if (lines_a.exists(tag))
    begin
      return lines_a[tag];
    end
    for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++)
    begin
      line[i] = pattern_word({tag, {cache_pkg::OFFSET_W{1'b0}}} + 32'(4 * i));
    end
    return line;
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      rsp_o   <= '0;
      wb_o    <= 1'b0;
      pending <= 1'b0;
      delay   <= 0;
    end
    else
    begin
      wb_o      <= 1'b0;
      rsp_o.ack <= 1'b0;
      // stall roughly one cycle in four
      rsp_o.stall <= (($urandom % 4) == 0);
      if (req_i.cyc && req_i.stb && !rsp_o.stall)
      begin
        if (req_i.op == bus_pkg::MEM_WRITE)
        begin
          lines_a[req_tag] = req_i.data;
          wb_o      <= 1'b1;
          wb_addr_o <= req_i.addr;
          wb_data_o <= req_i.data;
        end
        else
        begin
          fill_line <= read_line(req_tag);
          delay     <= $urandom % 4;
          pending   <= 1'b1;
        end
      end
      else if (pending)
      begin
        if (delay == 0)
        begin
          rsp_o.ack   <= 1'b1;
          rsp_o.rdata <= fill_line;
          pending     <= 1'b0;
        end
        else
        begin
          delay <= delay - 1;
        end
      end
    end
  end

endmodule

// ==== tb_cache_top.sv ====
`timescale 1ns/1ps

module tb_cache_top;

  localparam int NUM_LINES      = 8;
  localparam int FIFO_DEPTH     = 4;
  localparam int ACCEPT_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT  = 4000;

  logic                         clk;
  logic                         rst;
  logic                         cyc;
  logic                         stb;
  bus_pkg::cpu_req_t            cpu_req;
  logic                         stall;
  bus_pkg::cpu_rsp_t            cpu_rsp;
  bus_pkg::mem_req_t            mem_req;
  bus_pkg::mem_rsp_t            mem_rsp;
  logic                         wb;
  logic [cache_pkg::ADDR_W-1:0] wb_addr;
  cache_pkg::line_t             wb_data;

  // expected memory contents, word address to word
  logic [31:0]                  ref_mem [logic [29:0]];
  bus_pkg::cpu_req_t            issued_q [$];
  logic [cache_pkg::ADDR_W-1:0] wb_q [$];
  int unsigned                  stall_seen;

  cache_top #(.NUM_LINES(NUM_LINES), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk       (clk),
    .rst       (rst),
    .cyc_i     (cyc),
    .stb_i     (stb),
    .cpu_req_i (cpu_req),
    .stall_o   (stall),
    .cpu_rsp_o (cpu_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  tb_mem_model u_mem (
    .clk       (clk),
    .rst       (rst),
    .req_i     (mem_req),
    .rsp_o     (mem_rsp),
    .wb_o      (wb),
    .wb_addr_o (wb_addr),
    .wb_data_o (wb_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic logic [31:0] ref_word(input logic [29:0] waddr);
    if (ref_mem.exists(waddr))
    begin
      return ref_mem[waddr];
    end
    return pattern_word({waddr, 2'b00});
  endfunction

  // applies a write under sel, returns the word the cpu should see
  function automatic logic [31:0] ref_access(input bus_pkg::cpu_req_t req);
    logic [29:0] waddr;
    logic [31:0] word;
    logic [31:0] seen;
    waddr = req.addr[31:2];
    word  = ref_word(waddr);
    seen  = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (req.sel[b])
      begin
        if (req.we)
        begin
          word[b*8 +: 8] = req.wdata[b*8 +: 8];
        end
        seen[b*8 +: 8] = word[b*8 +: 8];
      end
    end
    if (req.we)
    begin
      ref_mem[waddr] = word;
    end
    return seen;
  endfunction

  function automatic cache_pkg::line_t ref_line(input logic [31:0] addr);
    cache_pkg::line_t line;
    for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++)
    begin
      line[i] = ref_word(addr[31:2] + 30'(i));
    end
    return line;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input bus_pkg::cpu_rsp_t got, input bus_pkg::cpu_rsp_t exp,
                            input logic [31:0] addr);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t read data at %08h is %08h, expected %08h",
                          $time, addr, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_line(input cache_pkg::line_t got, input cache_pkg::line_t exp,
                            input logic [31:0] addr);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t write-back of line %08h is %032h, expected %032h",
                          $time, addr, got, exp));
    end
  endtask

  task automatic check_addr(input logic [cache_pkg::ADDR_W-1:0] got,
                            input logic [cache_pkg::ADDR_W-1:0] exp, input string what);
    if (got !== exp)
    begin
      abort_run($sformatf("[FAIL] t=%0t %s is %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  // called just after a rising edge, returns at the edge that accepts
  task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic we, input logic [3:0] sel);
    bus_pkg::cpu_req_t req;
    int                cycles;
    req.addr  = addr;
    req.wdata = wdata;
    req.we    = we;
    req.sel   = sel;
    cycles    = 0;
    cyc     <= 1'b1;
    stb     <= 1'b1;
    cpu_req <= req;
    @(posedge clk);
    while (stall)
    begin
      cycles++;
      if (cycles > ACCEPT_TIMEOUT)
      begin
        abort_run($sformatf("timeout: request to %08h was never accepted", addr));
      end
      @(posedge clk);
    end
    issued_q.push_back(req);
  endtask

  task automatic wait_all_acked();
    int                     cycles;
    cache_pkg::ctrl_state_e st;
    cycles = 0;
    cyc <= 1'b0;
    stb <= 1'b0;
    @(negedge clk);
    while (issued_q.size() != 0)
    begin
      cycles++;
      if (cycles > DRAIN_TIMEOUT)
      begin
        st = uut.u_cache_ctrl.state_q;
        abort_run($sformatf("timeout: %0d requests still waiting for ack, controller in %s",
                            issued_q.size(), st.name()));
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  // pairs acks with accepted requests, checks write-backs
  always @(posedge clk)
  begin
    bus_pkg::cpu_req_t req;
    bus_pkg::cpu_rsp_t exp;
    if (!rst)
    begin
      if (cyc && stb && stall)
      begin
        stall_seen++;
      end
      if (cpu_rsp.ack)
      begin
        if (issued_q.size() == 0)
        begin
          abort_run("ack arrived with no outstanding request");
        end
        req       = issued_q.pop_front();
        exp.ack   = 1'b1;
        exp.rdata = ref_access(req);
        check_word(cpu_rsp, exp, req.addr);
      end
      if (wb)
      begin
        check_line(wb_data, ref_line(wb_addr), wb_addr);
        wb_q.push_back(wb_addr);
      end
      if (issued_q.size() > FIFO_DEPTH + 1)
      begin
        abort_run("more requests outstanding than the queue can hold");
      end
    end
  end

  initial
  begin
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [3:0]  sel;
    rst          = 1'b1;
    cyc          = 1'b0;
    stb          = 1'b0;
    cpu_req      = '0;
    stall_seen   = 0;
    void'($urandom(32'h075661d6));
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // unwritten lines give the fill pattern
    for (int k = 0; k < 4; k++)
    begin
      addr = 32'h0000_1000 + 32'(k * 16) + 32'(($urandom % 4) * 4);
      sel  = 4'($urandom % 15 + 1);
      send_req(addr, 32'h0, 1'b0, sel);
    end
    wait_all_acked();

    // partial write then full read
    send_req(32'h0000_2004, 32'hdead_beef, 1'b1, 4'b0101);
    send_req(32'h0000_2004, 32'h0, 1'b0, 4'hf);
    wait_all_acked();

    // nine dirty lines in eight ways
    wb_q.delete();
    for (int k = 0; k < 9; k++)
    begin
      wdata = $urandom;
      send_req(32'h0000_3000 + 32'(k * 16), wdata, 1'b1, 4'hf);
    end
    wait_all_acked();
    if (wb_q.size() == 0)
    begin
      abort_run("no write-back seen after writing nine lines");
    end
    check_addr(wb_q[$], 32'h0000_3000, "last write-back address");
    for (int k = 0; k < 4; k++)
    begin
      send_req(32'h0000_3000 + 32'(k * 4), 32'h0, 1'b0, 4'hf);
    end
    wait_all_acked();

    // lru victim after retouching line 0
    for (int k = 0; k < 8; k++)
    begin
      wdata = $urandom;
      send_req(32'h0000_4000 + 32'(k * 16), wdata, 1'b1, 4'hf);
    end
    send_req(32'h0000_4000, 32'h0, 1'b0, 4'hf);
    wait_all_acked();
    wb_q.delete();
    send_req(32'h0000_4080, 32'h0, 1'b0, 4'hf);
    wait_all_acked();
    if (wb_q.size() != 1)
    begin
      abort_run($sformatf("[FAIL] t=%0t lru miss gave %0d write-backs, expected 1",
                          $time, wb_q.size()));
    end
    check_addr(wb_q[0], 32'h0000_4010, "lru write-back address");

    // clean victim, no write-back expected
    for (int k = 0; k < 8; k++)
    begin
      send_req(32'h0000_5000 + 32'(k * 16), 32'h0, 1'b0, 4'hf);
    end
    wait_all_acked();
    wb_q.delete();
    send_req(32'h0000_5080, 32'h0, 1'b0, 4'hf);
    wait_all_acked();
    if (wb_q.size() != 0)
    begin
      abort_run($sformatf("[FAIL] t=%0t clean victim wrote back line %08h", $time, wb_q[0]));
    end

    // random burst, longer than the queue
    stall_seen = 0;
    for (int n = 0; n < 40; n++)
    begin
      addr  = 32'h0000_6000 + 32'(($urandom % 12) * 16);
      addr  = addr + 32'(($urandom % 4) * 4);
      wdata = $urandom;
      we    = 1'($urandom % 2);
      sel   = 4'($urandom % 16);
      send_req(addr, wdata, we, sel);
    end
    wait_all_acked();
    if (stall_seen == 0)
    begin
      abort_run("stall_o never rose during the burst");
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== flist.f ====
cache_pkg.sv
bus_pkg.sv
req_fifo.sv
line_store.sv
lru_tracker.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

// ==== Bender.yml ====
package:
  name: line_cache

sources:
  - cache_pkg.sv
  - bus_pkg.sv
  - req_fifo.sv
  - line_store.sv
  - lru_tracker.sv
  - cache_ctrl.sv
  - cache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_cache_top.sv
